// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    // Data and address width
    localparam int XLEN = 32;
    // Register index width
    localparam int REG_INDEX_WIDTH = 5;

    // ----------------------------------------
    // Major opcodes, bits [6:0] of the word
    // ----------------------------------------
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // ----------------------------------------
    // ALU operations
    // ----------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        // Second operand straight through, for LUI
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

// ==== verilog/instruction_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder
    import core_pkg::*;
(
    input  logic [XLEN-1:0]            instruction,
    output opcode_e                    opcode,
    output alu_op_e                    alu_op,
    output logic [REG_INDEX_WIDTH-1:0] read_index_1,
    output logic [REG_INDEX_WIDTH-1:0] read_index_2,
    output logic [REG_INDEX_WIDTH-1:0] write_index,
    output logic                       read_enable_1,
    output logic                       read_enable_2,
    output logic                       write_enable,
    output logic                       branch_not_equal,
    output logic [XLEN-1:0]            immediate
);

    logic [2:0] funct3;

    // Fixed RV32I field positions
    assign funct3       = instruction[14:12];
    assign read_index_1 = instruction[19:15];
    assign read_index_2 = instruction[24:20];
    assign write_index  = instruction[11:7];

    // BNE differs from BEQ in funct3 bit 0 only
    assign branch_not_equal = funct3[0];

    always_comb
    begin
        // Unknown words fall out as an ALU op that writes nothing
        opcode        = OP_IMM;
        alu_op        = ALU_ADD;
        read_enable_1 = 1'b0;
        read_enable_2 = 1'b0;
        write_enable  = 1'b0;
        immediate     = '0;
        case (instruction[6:0])
            OP_REG:
            begin
                opcode        = OP_REG;
                read_enable_1 = 1'b1;
                read_enable_2 = 1'b1;
                write_enable  = 1'b1;
                case (funct3)
                    // funct7 bit 5 selects SUB
                    3'b000:  alu_op = instruction[30] ? ALU_SUB : ALU_ADD;
                    3'b111:  alu_op = ALU_AND;
                    3'b110:  alu_op = ALU_OR;
                    3'b100:  alu_op = ALU_XOR;
                    3'b010:  alu_op = ALU_SLT;
                    // Shifts and SLTU are not kept
                    default: write_enable = 1'b0;
                endcase
            end
            OP_IMM:
            begin
                // Only ADDI of the immediate group is kept
                read_enable_1 = 1'b1;
                write_enable  = (funct3 == 3'b000);
                immediate     = {{20{instruction[31]}}, instruction[31:20]};
            end
            OP_LUI:
            begin
                opcode       = OP_LUI;
                alu_op       = ALU_PASS_B;
                write_enable = 1'b1;
                immediate    = {instruction[31:12], 12'b0};
            end
            OP_LOAD:
            begin
                // Word loads only
                if (funct3 == 3'b010)
                begin
                    opcode        = OP_LOAD;
                    read_enable_1 = 1'b1;
                    write_enable  = 1'b1;
                end
                immediate = {{20{instruction[31]}}, instruction[31:20]};
            end
            OP_STORE:
            begin
                if (funct3 == 3'b010)
                begin
                    opcode        = OP_STORE;
                    read_enable_1 = 1'b1;
                    read_enable_2 = 1'b1;
                end
                immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            OP_BRANCH:
            begin
                // BEQ and BNE only
                if (funct3[2:1] == 2'b00)
                begin
                    opcode        = OP_BRANCH;
                    read_enable_1 = 1'b1;
                    read_enable_2 = 1'b1;
                end
                immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
            end
            OP_JAL:
            begin
                opcode       = OP_JAL;
                write_enable = 1'b1;
                immediate    = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                                instruction[20], instruction[30:21], 1'b0};
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file
    import core_pkg::*;
(
    input  logic                       CLK,
    input  logic                       reset,
    input  logic [REG_INDEX_WIDTH-1:0] read_index_1,
    input  logic [REG_INDEX_WIDTH-1:0] read_index_2,
    input  logic                       write_enable,
    input  logic [REG_INDEX_WIDTH-1:0] write_index,
    input  logic [XLEN-1:0]            write_data,
    output logic [XLEN-1:0]            read_data_1,
    output logic [XLEN-1:0]            read_data_2
);

    localparam int REGISTER_COUNT = 2 ** REG_INDEX_WIDTH;

    // x0 has no storage
    logic [XLEN-1:0] registers [1:REGISTER_COUNT-1];

    // Zero for x0, new value on a same-cycle write, else stored value
    function automatic logic [XLEN-1:0] read_port(input logic [REG_INDEX_WIDTH-1:0] index);
        if (index == '0)
            return '0;
        else if (write_enable && index == write_index)
            return write_data;
        else
            return registers[index];
    endfunction

    always_comb
    begin
        read_data_1 = read_port(read_index_1);
        read_data_2 = read_port(read_index_2);
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 1; i < REGISTER_COUNT; i++)
                registers[i] <= '0;
        end
        else if (write_enable && write_index != '0)
            registers[write_index] <= write_data;
    end

    // A write aimed at x0 leaves x0 reading zero afterwards
    x0_stays_zero: assert property (@(posedge CLK) disable iff (reset)
        (write_enable && write_index == '0) |=> (read_index_1 != '0 || read_data_1 == '0));

endmodule

`default_nettype wire

// ==== verilog/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit
    import core_pkg::*;
(
    input  opcode_e         opcode,
    input  alu_op_e         alu_op,
    input  logic            branch_not_equal,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] operand_1,
    input  logic [XLEN-1:0] operand_2,
    input  logic [XLEN-1:0] immediate,
    output logic [XLEN-1:0] result,
    output logic [XLEN-1:0] data_address,
    output logic            branch_taken,
    output logic [XLEN-1:0] branch_target
);

    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic            operands_equal;

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    // ADDI and LUI take the immediate as second operand
    assign operand_b = (opcode == OP_IMM || opcode == OP_LUI) ? immediate : operand_2;

    always_comb
    begin
        case (alu_op)
            ALU_ADD:    alu_result = operand_1 + operand_b;
            ALU_SUB:    alu_result = operand_1 - operand_b;
            ALU_AND:    alu_result = operand_1 & operand_b;
            ALU_OR:     alu_result = operand_1 | operand_b;
            ALU_XOR:    alu_result = operand_1 ^ operand_b;
            // Signed compare, result is 0 or 1
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(operand_1) < $signed(operand_b)};
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // Link address for JAL
    assign result = (opcode == OP_JAL) ? pc + XLEN'(4) : alu_result;

    // ----------------------------------------
    // Addresses and branch decision
    // ----------------------------------------
    // Load and store effective address
    assign data_address  = operand_1 + immediate;
    // B and J immediates are both pc-relative
    assign branch_target = pc + immediate;

    assign operands_equal = (operand_1 == operand_2);

    // JAL always redirects, BEQ/BNE on the compare
    assign branch_taken = (opcode == OP_JAL) ||
                          (opcode == OP_BRANCH && (operands_equal ^ branch_not_equal));

endmodule

`default_nettype wire

// ==== verilog/hazard_forward_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_forward_unit
    import core_pkg::*;
(
    // Decode sources, index zero when the source is not read
    input  logic [REG_INDEX_WIDTH-1:0] read_index_1,
    input  logic [REG_INDEX_WIDTH-1:0] read_index_2,
    input  logic [XLEN-1:0]            register_data_1,
    input  logic [XLEN-1:0]            register_data_2,
    // Execute stage producer
    input  logic [REG_INDEX_WIDTH-1:0] execute_index,
    input  logic                       execute_write,
    input  logic                       execute_is_load,
    input  logic [XLEN-1:0]            execute_result,
    // Memory stage producer
    input  logic [REG_INDEX_WIDTH-1:0] memory_index,
    input  logic                       memory_write,
    input  logic [XLEN-1:0]            memory_result,
    // Write-back stage producer
    input  logic [REG_INDEX_WIDTH-1:0] writeback_index,
    input  logic                       writeback_write,
    input  logic [XLEN-1:0]            writeback_data,
    output logic [XLEN-1:0]            operand_1,
    output logic [XLEN-1:0]            operand_2,
    output logic                       stall
);

    // Youngest older producer first, x0 never forwarded
    function automatic logic [XLEN-1:0] forward(
        input logic [REG_INDEX_WIDTH-1:0] index,
        input logic [XLEN-1:0]            register_value
    );
        if (index == '0)
            return register_value;
        // A load in execute has no data yet, the stall covers it
        else if (execute_write && !execute_is_load && index == execute_index)
            return execute_result;
        else if (memory_write && index == memory_index)
            return memory_result;
        else if (writeback_write && index == writeback_index)
            return writeback_data;
        else
            return register_value;
    endfunction

    always_comb
    begin
        operand_1 = forward(read_index_1, register_data_1);
        operand_2 = forward(read_index_2, register_data_2);
    end

    // Load-use: the load in execute feeds a source read in decode
    assign stall = execute_write && execute_is_load && execute_index != '0 &&
                   (execute_index == read_index_1 || execute_index == read_index_2);

endmodule

`default_nettype wire

// ==== verilog/pipeline_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_core
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_ADDRESS = '0
)
(
    input  logic            CLK,
    input  logic            reset,
    output logic [XLEN-1:0] instruction_address,
    input  logic [XLEN-1:0] instruction,
    output logic [XLEN-1:0] data_address,
    output logic [XLEN-1:0] store_data,
    output logic            load_enable,
    output logic            store_enable,
    input  logic [XLEN-1:0] load_data
);

    // ----------------------------------------
    // Stage signals
    // ----------------------------------------
    logic [XLEN-1:0] pc;

    // Decode
    logic                       decode_valid;
    logic [XLEN-1:0]            decode_pc;
    logic [XLEN-1:0]            decode_instruction;
    opcode_e                    decode_opcode;
    alu_op_e                    decode_alu_op;
    logic [REG_INDEX_WIDTH-1:0] decode_read_index_1;
    logic [REG_INDEX_WIDTH-1:0] decode_read_index_2;
    logic [REG_INDEX_WIDTH-1:0] decode_write_index;
    logic                       decode_read_enable_1;
    logic                       decode_read_enable_2;
    logic                       decode_write_enable;
    logic                       decode_branch_not_equal;
    logic [XLEN-1:0]            decode_immediate;
    logic [XLEN-1:0]            register_data_1;
    logic [XLEN-1:0]            register_data_2;
    logic [XLEN-1:0]            forward_operand_1;
    logic [XLEN-1:0]            forward_operand_2;
    logic                       stall;

    // Execute
    logic                       execute_valid;
    logic [XLEN-1:0]            execute_pc;
    opcode_e                    execute_opcode;
    alu_op_e                    execute_alu_op;
    logic                       execute_branch_not_equal;
    logic [XLEN-1:0]            execute_operand_1;
    logic [XLEN-1:0]            execute_operand_2;
    logic [XLEN-1:0]            execute_immediate;
    logic [REG_INDEX_WIDTH-1:0] execute_write_index;
    logic                       execute_write_enable;
    logic [XLEN-1:0]            execute_result;
    logic [XLEN-1:0]            execute_address;
    logic                       execute_branch_taken;
    logic [XLEN-1:0]            execute_branch_target;
    logic                       redirect;

    // Memory
    logic                       memory_valid;
    logic                       memory_is_load;
    logic                       memory_is_store;
    logic [REG_INDEX_WIDTH-1:0] memory_write_index;
    logic                       memory_write_enable;
    logic [XLEN-1:0]            memory_result;
    logic [XLEN-1:0]            memory_address;
    logic [XLEN-1:0]            memory_store_data;

    // Write-back
    logic                       writeback_valid;
    logic                       writeback_is_load;
    logic [REG_INDEX_WIDTH-1:0] writeback_index;
    logic                       writeback_write_enable;
    logic [XLEN-1:0]            writeback_result;
    logic [XLEN-1:0]            writeback_load_data;
    logic [XLEN-1:0]            writeback_data;
    logic                       writeback_write;

    // ----------------------------------------
    // Control: PC, valid bits, stall, flush
    // ----------------------------------------
    assign instruction_address = pc;

    // Taken branch or JAL in execute
    assign redirect = execute_valid && execute_branch_taken;

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            pc              <= RESET_ADDRESS;
            decode_valid    <= 1'b0;
            execute_valid   <= 1'b0;
            memory_valid    <= 1'b0;
            writeback_valid <= 1'b0;
        end
        else
        begin
            memory_valid    <= execute_valid;
            writeback_valid <= memory_valid;
            if (redirect)
            begin
                // Fetch and decode hold the two younger instructions
                pc            <= execute_branch_target;
                decode_valid  <= 1'b0;
                execute_valid <= 1'b0;
            end
            else if (stall)
                // PC and decode hold, bubble into execute
                execute_valid <= 1'b0;
            else
            begin
                pc            <= pc + XLEN'(4);
                decode_valid  <= 1'b1;
                execute_valid <= decode_valid;
            end
        end
    end

    // ----------------------------------------
    // Pipeline payload registers
    // ----------------------------------------
    always_ff @(posedge CLK)
    begin
        if (!stall)
        begin
            decode_pc          <= pc;
            decode_instruction <= instruction;
        end
        execute_pc               <= decode_pc;
        execute_opcode           <= decode_opcode;
        execute_alu_op           <= decode_alu_op;
        execute_branch_not_equal <= decode_branch_not_equal;
        execute_operand_1        <= forward_operand_1;
        execute_operand_2        <= forward_operand_2;
        execute_immediate        <= decode_immediate;
        execute_write_index      <= decode_write_index;
        execute_write_enable     <= decode_write_enable;
        // Execute to memory
        memory_is_load      <= (execute_opcode == OP_LOAD);
        memory_is_store     <= (execute_opcode == OP_STORE);
        memory_write_index  <= execute_write_index;
        memory_write_enable <= execute_write_enable;
        memory_result       <= execute_result;
        memory_address      <= execute_address;
        memory_store_data   <= execute_operand_2;
        // Memory to write-back
        writeback_is_load      <= memory_is_load;
        writeback_index        <= memory_write_index;
        writeback_write_enable <= memory_write_enable;
        writeback_result       <= memory_result;
        writeback_load_data    <= load_data;
    end

    // Data port driven from the memory stage
    assign data_address = memory_address;
    assign store_data   = memory_store_data;
    assign load_enable  = memory_valid && memory_is_load;
    assign store_enable = memory_valid && memory_is_store;

    // Write-back data select
    assign writeback_data  = writeback_is_load ? writeback_load_data : writeback_result;
    assign writeback_write = writeback_valid && writeback_write_enable;

    // ----------------------------------------
    // Submodules
    // ----------------------------------------
    instruction_decoder decoder0 (
        .instruction      (decode_instruction),
        .opcode           (decode_opcode),
        .alu_op           (decode_alu_op),
        .read_index_1     (decode_read_index_1),
        .read_index_2     (decode_read_index_2),
        .write_index      (decode_write_index),
        .read_enable_1    (decode_read_enable_1),
        .read_enable_2    (decode_read_enable_2),
        .write_enable     (decode_write_enable),
        .branch_not_equal (decode_branch_not_equal),
        .immediate        (decode_immediate)
    );

    register_file register_file0 (
        .CLK          (CLK),
        .reset        (reset),
        .read_index_1 (decode_read_index_1),
        .read_index_2 (decode_read_index_2),
        .write_enable (writeback_write),
        .write_index  (writeback_index),
        .write_data   (writeback_data),
        .read_data_1  (register_data_1),
        .read_data_2  (register_data_2)
    );

    // Unread sources go in as x0 so they never forward or stall
    hazard_forward_unit hazard0 (
        .read_index_1    (decode_read_enable_1 ? decode_read_index_1 : '0),
        .read_index_2    (decode_read_enable_2 ? decode_read_index_2 : '0),
        .register_data_1 (register_data_1),
        .register_data_2 (register_data_2),
        .execute_index   (execute_write_index),
        .execute_write   (execute_valid && execute_write_enable),
        .execute_is_load (execute_opcode == OP_LOAD),
        .execute_result  (execute_result),
        .memory_index    (memory_write_index),
        .memory_write    (memory_valid && memory_write_enable),
        // Load data arrives in the memory stage itself
        .memory_result   (memory_is_load ? load_data : memory_result),
        .writeback_index (writeback_index),
        .writeback_write (writeback_write),
        .writeback_data  (writeback_data),
        .operand_1       (forward_operand_1),
        .operand_2       (forward_operand_2),
        .stall           (stall)
    );

    execute_unit execute0 (
        .opcode           (execute_opcode),
        .alu_op           (execute_alu_op),
        .branch_not_equal (execute_branch_not_equal),
        .pc               (execute_pc),
        .operand_1        (execute_operand_1),
        .operand_2        (execute_operand_2),
        .immediate        (execute_immediate),
        .result           (execute_result),
        .data_address     (execute_address),
        .branch_taken     (execute_branch_taken),
        .branch_target    (execute_branch_target)
    );

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    load_store_exclusive: assert property (@(posedge CLK) disable iff (reset)
        !(load_enable && store_enable));

    // Stall only behind a valid load, and the bubble clears it next cycle
    stall_single_cycle: assert property (@(posedge CLK) disable iff (reset)
        stall |-> (execute_valid && execute_opcode == OP_LOAD) ##1 !stall);

endmodule

`default_nettype wire

// ==== tests/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb
    import core_pkg::*;
();

    localparam int    MEMORY_DEPTH_WORDS  = 1024;
    localparam int    ADDRESS_BITS        = $clog2(MEMORY_DEPTH_WORDS);
    localparam int    RESET_CYCLES        = 10;
    localparam int    CYCLES_PER_WORD     = 8;
    localparam string STIMULUS_FILE       = "tests/core_stimulus.txt";
    // The program signals its end with a store here
    localparam logic [XLEN-1:0] FINAL_STORE_ADDRESS = 32'h0000_0FFC;

    logic            CLK;
    logic            reset;
    logic [XLEN-1:0] instruction_address;
    logic [XLEN-1:0] instruction;
    logic [XLEN-1:0] data_address;
    logic [XLEN-1:0] store_data;
    logic            load_enable;
    logic            store_enable;
    logic [XLEN-1:0] load_data;

    // Instruction and data memories, word addressed
    logic [XLEN-1:0] imem [0:MEMORY_DEPTH_WORDS-1];
    logic [XLEN-1:0] dmem [0:MEMORY_DEPTH_WORDS-1];

    // Expected store sequence
    logic [XLEN-1:0] expected_address [$];
    logic [XLEN-1:0] expected_data [$];

    int   program_words   = 0;
    int   store_count     = 0;
    int   mismatch_count  = 0;
    int   sequence_errors = 0;
    int   other_errors    = 0;
    logic stimulus_loaded = 1'b0;
    logic run_done        = 1'b0;

    pipeline_core #(
        .RESET_ADDRESS (32'h0000_0000)
    ) dut0 (
        .CLK                 (CLK),
        .reset               (reset),
        .instruction_address (instruction_address),
        .instruction         (instruction),
        .data_address        (data_address),
        .store_data          (store_data),
        .load_enable         (load_enable),
        .store_enable        (store_enable),
        .load_data           (load_data)
    );

    // 4 ns period
    always #2 CLK = ~CLK;

    // ----------------------------------------
    // Memory models
    // ----------------------------------------
    // Both ports answer in the same cycle
    assign instruction = imem[instruction_address[ADDRESS_BITS+1:2]];
    // Data port returns the word only while a load is requested
    assign load_data   = load_enable ? dmem[data_address[ADDRESS_BITS+1:2]] : '0;

    always @(posedge CLK)
    begin
        if (!reset && store_enable)
            dmem[data_address[ADDRESS_BITS+1:2]] <= store_data;
    end

    task automatic fill_memories();
        logic [ADDRESS_BITS-1:0] word_index;
        for (int i = 0; i < MEMORY_DEPTH_WORDS; i++)
        begin
            word_index = ADDRESS_BITS'(i);
            // Opcode field zero, runs as a bubble
            imem[word_index] = XLEN'(i) << 7;
            dmem[word_index] = {~16'(i), 16'(i)};
        end
    endtask

    task automatic load_stimulus();
        int               fd;
        int               count;
        logic [7:0]       tag;
        logic [XLEN-1:0]  first_value;
        logic [XLEN-1:0]  second_value;
        logic [8*200-1:0] rest;
        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open %s for reading", STIMULUS_FILE);
            other_errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                count = $fscanf(fd, " %c", tag);
                if (count == 1)
                begin
                    case (tag)
                        "I":
                        begin
                            count = $fscanf(fd, "%h", first_value);
                            imem[ADDRESS_BITS'(program_words)] = first_value;
                            program_words++;
                        end
                        "D":
                        begin
                            count = $fscanf(fd, "%h %h", first_value, second_value);
                            dmem[first_value[ADDRESS_BITS+1:2]] = second_value;
                        end
                        "E":
                        begin
                            count = $fscanf(fd, "%h %h", first_value, second_value);
                            expected_address.push_back(first_value);
                            expected_data.push_back(second_value);
                        end
                        default:
                        begin
                        end
                    endcase
                    // Rest of the line is free text
                    count = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // Store checking
    // ----------------------------------------
    task automatic check_store(input logic [XLEN-1:0] address, input logic [XLEN-1:0] data);
        assert (store_count < expected_address.size())
        else
        begin
            $display("Unexpected extra store number %0d to %08h with data %08h",
                     store_count, address, data);
            sequence_errors++;
        end
        if (store_count < expected_address.size())
        begin
            assert (address == expected_address[store_count])
            else
            begin
                $display("MISMATCH data_address store %0d: got %08h expected %08h",
                         store_count, address, expected_address[store_count]);
                mismatch_count++;
            end
            assert (data == expected_data[store_count])
            else
            begin
                $display("MISMATCH store_data store %0d: got %08h expected %08h",
                         store_count, data, expected_data[store_count]);
                mismatch_count++;
            end
        end
        store_count++;
    endtask

    // Memory stage outputs are settled by the falling edge
    always @(negedge CLK)
    begin
        if (!reset)
        begin
            // One data port access per cycle
            assert (!(load_enable && store_enable))
            else
            begin
                $display("Load and store requested together at address %08h", data_address);
                other_errors++;
            end
            if (store_enable)
            begin
                check_store(data_address, store_data);
                if (data_address == FINAL_STORE_ADDRESS)
                    run_done = 1'b1;
            end
        end
    end

    task automatic report_and_finish();
        $display("Stores seen %0d of %0d, mismatches %0d, sequence errors %0d, other errors %0d",
                 store_count, expected_address.size(), mismatch_count, sequence_errors,
                 other_errors);
        if (mismatch_count + sequence_errors + other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial
    begin
        CLK   = 1'b0;
        reset = 1'b1;
        fill_memories();
        load_stimulus();
        stimulus_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge CLK);
        reset = 1'b0;
        wait (run_done);
        // Final store came before the list ran out
        assert (store_count >= expected_address.size())
        else
        begin
            $display("Only %0d of %0d expected stores happened before the final store",
                     store_count, expected_address.size());
            sequence_errors++;
        end
        report_and_finish();
    end

    initial
    begin
        int timeout_cycles;
        wait (stimulus_loaded);
        timeout_cycles = RESET_CYCLES + CYCLES_PER_WORD * program_words;
        repeat (timeout_cycles) @(posedge CLK);
        $display("Timeout: no store to %08h within %0d cycles",
                 FINAL_STORE_ADDRESS, timeout_cycles);
        other_errors++;
        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== tests/core_stimulus.txt ====
# Tag I: one instruction word in hex, placed from address 0 upward; text after it is ignored
# Tag D: byte address and initial data word; tag E: expected store address and data, in order
I 03C00093  addi x1, x0, 0x3C
I 06500113  addi x2, x0, 0x65
I 002081B3  add  x3, x1, x2
I 40308233  sub  x4, x1, x3
I 10402023  sw   x4, 0x100(x0)
I 0021F2B3  and  x5, x3, x2
I 0012E333  or   x6, x5, x1
I 004343B3  xor  x7, x6, x4
I 00522433  slt  x8, x4, x5
I 10702223  sw   x7, 0x104(x0)
I 10802423  sw   x8, 0x108(x0)
I 123454B7  lui  x9, 0x12345
I 67848493  addi x9, x9, 0x678
I 10902623  sw   x9, 0x10C(x0)
I 20002503  lw   x10, 0x200(x0)
I 20402603  lw   x12, 0x204(x0)
I 00C505B3  add  x11, x10, x12
I 10B02823  sw   x11, 0x110(x0)
I 00208463  beq  x1, x2, +8 not taken
I 10102A23  sw   x1, 0x114(x0)
I 00318663  beq  x3, x3, +12 taken
I 1E202823  sw   x2, 0x1F0(x0) skipped
I 1E302A23  sw   x3, 0x1F4(x0) skipped
I 00109463  bne  x1, x1, +8 not taken
I 10202C23  sw   x2, 0x118(x0)
I 00209663  bne  x1, x2, +12 taken
I 1E102C23  sw   x1, 0x1F8(x0) skipped
I 1E102E23  sw   x1, 0x1FC(x0) skipped
I 00C006EF  jal  x13, +12
I 7FF00693  addi x13, x0, 0x7FF skipped
I 1E102A23  sw   x1, 0x1F4(x0) skipped
I 10D02E23  sw   x13, 0x11C(x0)
I 07B00013  addi x0, x0, 0x7B
I 12002023  sw   x0, 0x120(x0)
I 000017B7  lui  x15, 1
I FE17AE23  sw   x1, -4(x15) final store
D 00000200 00001111
D 00000204 0F0F0F0F
E 00000100 FFFFFF9B
E 00000104 FFFFFFA6
E 00000108 00000001
E 0000010C 12345678
E 00000110 0F0F2020
E 00000114 0000003C
E 00000118 00000065
E 0000011C 00000074
E 00000120 00000000
E 00000FFC 0000003C

// ==== all.f ====
verilog/core_pkg.sv
verilog/instruction_decoder.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/hazard_forward_unit.sv
verilog/pipeline_core.sv
tests/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
